// ==== Makefile ====
.PHONY: run clean

run: obj_dir/VtbCameraConfig
	./obj_dir/VtbCameraConfig

obj_dir/VtbCameraConfig: flist.f $(shell cat flist.f)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tbCameraConfig -f flist.f

clean:
	rm -rf obj_dir

// ==== design/camCfgPkg.sv ====
package camCfgPkg;

   // sensor on the bus
   localparam logic [7:0]  SensorAddr     = 8'h6C;   // write address, read sets bit 0
   localparam logic [15:0] ChipIdReg      = 16'h300B;
   localparam logic [7:0]  ChipIdExpected = 8'h88;

   // sequencing, in CLK_400K cycles
   localparam int SettleCycles = 6;   // wait after reset
   localparam int GapCycles    = 3;   // idle between bus operations
   localparam int TableLength  = 24;

   // one quarter of an scl period, a bit is four quarters
   localparam int QuarterCycles = 1;

   typedef logic [4:0] tableIndex_t;

   typedef enum logic [1:0] {
      opWritePointer,   // addr + 16-bit register
      opWriteWord,      // addr + register + data byte
      opReadByte        // addr with read bit + one data byte
   } i2cOp_t;

   typedef enum logic {
      entryWrite,
      entryDelay
   } entryKind_t;

   typedef enum logic [3:0] {
      stSettle,
      stIdPointer,
      stGap,
      stIdRead,
      stCheck,
      stTableFetch,
      stTableWrite,
      stDelay,
      stReleased
   } seqState_t;

   typedef struct packed {
      i2cOp_t      op;
      logic [7:0]  slaveAddr;
      logic [15:0] regAddr;
      logic [7:0]  data;
   } i2cCmd_t;

   // data carries the hold-off count for a delay entry
   typedef struct packed {
      entryKind_t  kind;
      logic [7:0]  slaveAddr;
      logic [15:0] regAddr;
      logic [7:0]  data;
   } configEntry_t;

endpackage

// ==== design/cameraConfig.sv ====
`timescale 1ns/1ps

module cameraConfig (
   input  logic       CLK_400K,
   input  logic       RESET_N,
   output logic       i2cScl,
   inout  wire        i2cSda,
   output logic [7:0] chipId,
   output logic       cameraRelease
);
   import camCfgPkg::*;

   tableIndex_t  index;
   configEntry_t entry;
   i2cCmd_t      cmd;
   logic         go;
   logic         done;
   logic [7:0]   rdData;
   logic         sclLow;
   logic         sdaLow;

   configSequencer i_configSequencer (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .index         (index),
      .entry         (entry),
      .cmd           (cmd),
      .go            (go),
      .done          (done),
      .rdData        (rdData),
      .chipId        (chipId),
      .cameraRelease (cameraRelease)
   );

   configTable i_configTable (
      .CLK_400K (CLK_400K),
      .index    (index),
      .entry    (entry)
   );

   i2cMaster i_i2cMaster (
      .CLK_400K (CLK_400K),
      .RESET_N  (RESET_N),
      .cmd      (cmd),
      .go       (go),
      .done     (done),
      .rdData   (rdData),
      .sclLow   (sclLow),
      .sdaLow   (sdaLow),
      .sdaIn    (i2cSda)
   );

   // open drain, pull-ups sit on the board
   assign i2cScl = sclLow ? 1'b0 : 1'bz;
   assign i2cSda = sdaLow ? 1'b0 : 1'bz;

endmodule

// ==== design/configSequencer.sv ====
`timescale 1ns/1ps

module configSequencer (
   input  logic                    CLK_400K,
   input  logic                    RESET_N,
   output camCfgPkg::tableIndex_t  index,
   input  camCfgPkg::configEntry_t entry,
   output camCfgPkg::i2cCmd_t      cmd,
   output logic                    go,
   input  logic                    done,
   input  logic [7:0]              rdData,
   output logic [7:0]              chipId,
   output logic                    cameraRelease
);
   import camCfgPkg::*;

   seqState_t  state;
   seqState_t  afterGap;    // state entered when the gap runs out
   logic [7:0] waitCnt;     // settle, gap and delay counter
   logic       lastEntry;

   assign lastEntry = (index == tableIndex_t'(TableLength - 1));

   function automatic i2cCmd_t idCmd(input i2cOp_t op);
      return '{op: op, slaveAddr: SensorAddr, regAddr: ChipIdReg, data: 8'h00};
   endfunction

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         state         <= stSettle;
         afterGap      <= stSettle;
         waitCnt       <= '0;
         index         <= '0;
         cmd           <= idCmd(opWritePointer);
         go            <= 1'b0;
         chipId        <= '0;
         cameraRelease <= 1'b0;
      end else begin
         go <= 1'b0;   // strobe
         case (state)
            stSettle: begin
               if (waitCnt == 8'(SettleCycles - 1)) begin
                  cmd   <= idCmd(opWritePointer);
                  go    <= 1'b1;
                  state <= stIdPointer;
               end else begin
                  waitCnt <= waitCnt + 8'd1;
               end
            end
            stIdPointer: begin
               if (done) begin
                  waitCnt  <= '0;
                  afterGap <= stIdRead;
                  state    <= stGap;
               end
            end
            stGap: begin
               if (waitCnt == 8'(GapCycles - 1)) begin
                  state <= afterGap;
                  if (afterGap == stIdRead) begin
                     cmd <= idCmd(opReadByte);
                     go  <= 1'b1;
                  end
                  if (afterGap == stReleased)
                     cameraRelease <= 1'b1;   // held until reset
               end else begin
                  waitCnt <= waitCnt + 8'd1;
               end
            end
            stIdRead: begin
               if (done) begin
                  chipId   <= rdData;   // valid in the done cycle
                  waitCnt  <= '0;
                  afterGap <= stCheck;
                  state    <= stGap;
               end
            end
            stCheck: begin
               if (chipId == ChipIdExpected) begin
                  state <= stTableFetch;
               end else begin
                  cmd   <= idCmd(opWritePointer);   // wrong id, try again
                  go    <= 1'b1;
                  state <= stIdPointer;
               end
            end
            stTableFetch: begin
               waitCnt <= '0;
               if (entry.kind == entryDelay) begin
                  state <= stDelay;
               end else begin
                  cmd <= '{op:        opWriteWord,
                           slaveAddr: entry.slaveAddr,
                           regAddr:   entry.regAddr,
                           data:      entry.data};
                  go    <= 1'b1;
                  state <= stTableWrite;
               end
            end
            stTableWrite: begin
               if (done) begin
                  waitCnt <= '0;
                  state   <= stGap;
                  if (lastEntry) begin
                     afterGap <= stReleased;
                  end else begin
                     index    <= index + 5'd1;
                     afterGap <= stTableFetch;
                  end
               end
            end
            stDelay: begin
               if (waitCnt == entry.data) begin
                  waitCnt <= '0;
                  state   <= stGap;
                  if (lastEntry) begin
                     afterGap <= stReleased;
                  end else begin
                     index    <= index + 5'd1;
                     afterGap <= stTableFetch;
                  end
               end else begin
                  waitCnt <= waitCnt + 8'd1;
               end
            end
            stReleased: state <= stReleased;
            default:    state <= stSettle;
         endcase
      end
   end

endmodule

// ==== design/configTable.sv ====
`timescale 1ns/1ps

module configTable (
   input  logic                    CLK_400K,
   input  camCfgPkg::tableIndex_t  index,
   output camCfgPkg::configEntry_t entry
);
   import camCfgPkg::*;

   function automatic configEntry_t writeEntry(input logic [15:0] addr, input logic [7:0] value);
      return '{kind: entryWrite, slaveAddr: SensorAddr, regAddr: addr, data: value};
   endfunction

   function automatic configEntry_t delayEntry(input logic [7:0] cycles);
      return '{kind: entryDelay, slaveAddr: 8'h00, regAddr: 16'h0000, data: cycles};
   endfunction

   always_ff @(posedge CLK_400K) begin
      case (index)
         5'd0:    entry <= writeEntry(16'h0103, 8'h01);   // software reset
         5'd1:    entry <= writeEntry(16'h0103, 8'h01);
         5'd2:    entry <= delayEntry(8'd10);
         5'd3:    entry <= writeEntry(16'h0100, 8'h00);   // software standby
         5'd4:    entry <= writeEntry(16'h0100, 8'h00);
         5'd5:    entry <= writeEntry(16'h3638, 8'hFF);   // analog control
         5'd6:    entry <= writeEntry(16'h0302, 8'd24);   // pll1 multiplier
         5'd7:    entry <= writeEntry(16'h0303, 8'h00);   // pll1 divm
         5'd8:    entry <= delayEntry(8'd10);
         5'd9:    entry <= writeEntry(16'h0304, 8'h03);   // pll1 mipi div
         5'd10:   entry <= writeEntry(16'h030E, 8'h00);   // pll2 r divs
         5'd11:   entry <= writeEntry(16'h030F, 8'h04);
         5'd12:   entry <= writeEntry(16'h0312, 8'h01);   // pll2 pre div
         5'd13:   entry <= writeEntry(16'h031E, 8'h0C);
         5'd14:   entry <= writeEntry(16'h3015, 8'h01);   // clock div
         5'd15:   entry <= writeEntry(16'h3018, 8'h72);   // mipi 4 lane
         5'd16:   entry <= writeEntry(16'h3020, 8'h93);   // pclk/1
         5'd17:   entry <= writeEntry(16'h3808, 8'h02);   // x size 640
         5'd18:   entry <= writeEntry(16'h3809, 8'h80);
         5'd19:   entry <= writeEntry(16'h380A, 8'h01);   // y size 480
         5'd20:   entry <= writeEntry(16'h380B, 8'hE0);
         5'd21:   entry <= writeEntry(16'h380C, 8'h12);   // hts
         5'd22:   entry <= writeEntry(16'h380D, 8'h00);
         5'd23:   entry <= writeEntry(16'h0100, 8'h01);   // wake up, streaming
         default: entry <= delayEntry(8'd0);
      endcase
   end

endmodule

// ==== design/i2cMaster.sv ====
`timescale 1ns/1ps

module i2cMaster (
   input  logic               CLK_400K,
   input  logic               RESET_N,
   input  camCfgPkg::i2cCmd_t cmd,
   input  logic               go,
   output logic               done,
   output logic [7:0]         rdData,
   output logic               sclLow,
   output logic               sdaLow,
   input  logic               sdaIn
);
   import camCfgPkg::*;

   typedef enum logic [2:0] {
      phIdle,
      phStart,
      phBits,
      phAck,
      phStop
   } phase_t;

   phase_t     phase;
   logic [3:0] preCnt;       // clocks within a quarter
   logic [1:0] quarter;      // quarter of the scl period
   logic [2:0] bitCnt;
   logic [1:0] byteCnt;
   logic [1:0] lastByte;
   logic       quarterEnd;
   logic       slotEnd;      // last clock of a start, bit, ack or stop slot
   logic       driveData;
   i2cCmd_t    cmdReg;
   logic [7:0] txShift;
   logic [7:0] rxShift;

   function automatic logic [7:0] txByte(input i2cCmd_t c, input logic [1:0] idx);
      case (idx)
         2'd0:    return {c.slaveAddr[7:1], c.op == opReadByte};   // r/w bit
         2'd1:    return c.regAddr[15:8];
         2'd2:    return c.regAddr[7:0];
         default: return c.data;
      endcase
   endfunction

   assign quarterEnd = (preCnt == 4'(QuarterCycles - 1));
   assign slotEnd    = quarterEnd && (quarter == 2'd3);
   assign driveData  = !((cmdReg.op == opReadByte) && (byteCnt == 2'd1));
   assign done       = (phase == phStop) && slotEnd;
   assign rdData     = rxShift;

   always_comb begin
      case (cmdReg.op)
         opWritePointer: lastByte = 2'd2;
         opWriteWord:    lastByte = 2'd3;
         default:        lastByte = 2'd1;
      endcase
   end

   // scl low in quarters 0 and 3 of a bit, sda only moves there
   always_comb begin
      sclLow = 1'b0;
      sdaLow = 1'b0;
      case (phase)
         phStart: begin
            sdaLow = 1'b1;         // sda falls with scl high
            sclLow = quarter[1];
         end
         phBits: begin
            sclLow = (quarter == 2'd0) || (quarter == 2'd3);
            sdaLow = driveData && !txShift[7];
         end
         phAck: begin
            sclLow = (quarter == 2'd0) || (quarter == 2'd3);   // sda left free, nack on reads
         end
         phStop: begin
            sclLow = (quarter == 2'd0);
            sdaLow = !quarter[1];  // sda rises with scl high
         end
         default: ;
      endcase
   end

   always_ff @(posedge CLK_400K) begin
      if (!RESET_N) begin
         phase   <= phIdle;
         preCnt  <= '0;
         quarter <= '0;
         bitCnt  <= '0;
         byteCnt <= '0;
      end else if (phase == phIdle) begin
         if (go) begin
            phase   <= phStart;
            preCnt  <= '0;
            quarter <= '0;
         end
      end else if (quarterEnd) begin
         preCnt  <= '0;
         quarter <= quarter + 2'd1;
         if (quarter == 2'd3) begin
            case (phase)
               phStart: begin
                  phase   <= phBits;
                  bitCnt  <= '0;
                  byteCnt <= '0;
               end
               phBits: begin
                  bitCnt <= bitCnt + 3'd1;
                  if (bitCnt == 3'd7)
                     phase <= phAck;
               end
               phAck: begin
                  if (byteCnt == lastByte) begin
                     phase <= phStop;
                  end else begin
                     phase   <= phBits;
                     byteCnt <= byteCnt + 2'd1;
                  end
               end
               default: phase <= phIdle;   // end of stop
            endcase
         end
      end else begin
         preCnt <= preCnt + 4'd1;
      end
   end

   always_ff @(posedge CLK_400K) begin
      if ((phase == phIdle) && go)
         cmdReg <= cmd;
      if ((phase == phBits) && quarterEnd && (quarter == 2'd1))
         rxShift <= {rxShift[6:0], sdaIn};   // scl high midpoint
      if (slotEnd) begin
         if (phase == phStart)
            txShift <= txByte(cmdReg, 2'd0);
         else if (phase == phAck)
            txShift <= txByte(cmdReg, byteCnt + 2'd1);
         else if (phase == phBits)
            txShift <= {txShift[6:0], 1'b0};
      end
   end

endmodule

// ==== flist.f ====
design/camCfgPkg.sv
design/configTable.sv
design/i2cMaster.sv
design/configSequencer.sv
design/cameraConfig.sv
testbench/tbClock.sv
testbench/sensorModel.sv
testbench/tbCameraConfig.sv

// ==== testbench/cameraConfigVectors.txt ====
// kind_addr_reg_data in hex: kind 1 is an ID answer in the data byte, kind 2 an expected write,
// kind 3 the minimum idle cycles on the bus before the next write
1_00_0000_55
1_00_0000_3A
1_00_0000_88
2_6C_0103_01
2_6C_0103_01
3_00_0000_0D
2_6C_0100_00
2_6C_0100_00
2_6C_3638_FF
2_6C_0302_18
2_6C_0303_00
3_00_0000_0D
2_6C_0304_03
2_6C_030E_00
2_6C_030F_04
2_6C_0312_01
2_6C_031E_0C
2_6C_3015_01
2_6C_3018_72
2_6C_3020_93
2_6C_3808_02
2_6C_3809_80
2_6C_380A_01
2_6C_380B_E0
2_6C_380C_12
2_6C_380D_00
2_6C_0100_01

// ==== testbench/sensorModel.sv ====
`timescale 1ns/1ps

module sensorModel (
   input  logic        CLK_400K,
   input  logic        RESET_N,
   input  wire         scl,
   inout  wire         sda,
   input  logic [7:0]  idAnswer,
   output logic        startSeen,
   output logic        txnDone,
   output logic        txnRead,
   output logic [2:0]  txnLen,
   output logic [31:0] txnBytes
);
   logic       prevScl;
   logic       prevSda;
   logic       sdaLow;
   logic       inTxn;
   logic [3:0] bitPos;   // 8 is the ack slot, 15 waits for scl to fall after start
   logic [7:0] rxByte;
   logic [7:0] txByte;

   assign sda = sdaLow ? 1'b0 : 1'bz;

   // bus sampled half a clock away from the master's edges
   always @(negedge CLK_400K) begin
      startSeen <= 1'b0;
      txnDone   <= 1'b0;
      if (!RESET_N) begin
         prevScl  <= 1'b1;
         prevSda  <= 1'b1;
         sdaLow   <= 1'b0;
         inTxn    <= 1'b0;
         bitPos   <= '0;
         rxByte   <= '0;
         txByte   <= '0;
         txnRead  <= 1'b0;
         txnLen   <= '0;
         txnBytes <= '0;
      end else begin
         prevScl <= scl;
         prevSda <= sda;
         if (scl && prevScl && prevSda && !sda) begin
            startSeen <= 1'b1;   // sda fell with scl high
            inTxn     <= 1'b1;
            bitPos    <= 4'hF;
            txnRead   <= 1'b0;
            txnLen    <= '0;
            txnBytes  <= '0;
         end else if (scl && prevScl && !prevSda && sda) begin
            txnDone <= inTxn;    // stop
            inTxn   <= 1'b0;
            sdaLow  <= 1'b0;
         end else if (inTxn && scl && !prevScl) begin
            if (bitPos < 4'd8)
               rxByte <= {rxByte[6:0], sda};
         end else if (inTxn && !scl && prevScl) begin
            if (bitPos == 4'hF) begin
               bitPos <= '0;
            end else if (bitPos == 4'd7) begin
               bitPos   <= 4'd8;
               txnBytes <= {txnBytes[23:0], rxByte};
               txnLen   <= txnLen + 3'd1;
               sdaLow   <= !txnRead;   // ack writes, master nacks reads
            end else if (bitPos == 4'd8) begin
               bitPos <= '0;
               if ((txnLen == 3'd1) && txnBytes[0]) begin
                  txnRead <= 1'b1;     // read bit in the address byte
                  sdaLow  <= !idAnswer[7];
                  txByte  <= {idAnswer[6:0], 1'b0};
               end else begin
                  sdaLow <= 1'b0;
               end
            end else begin
               bitPos <= bitPos + 4'd1;
               if (txnRead) begin
                  sdaLow <= !txByte[7];
                  txByte <= {txByte[6:0], 1'b0};
               end
            end
         end
      end
   end

endmodule

// ==== testbench/tbCameraConfig.sv ====
`timescale 1ns/1ps

module tbCameraConfig;
   import camCfgPkg::*;

   typedef struct packed {
      logic [7:0]  slaveAddr;
      logic [15:0] regAddr;
      logic [7:0]  data;
   } busWrite_t;

   localparam int VectorDepth = 64;
   localparam int TailCycles  = 400;   // quiet bus watched after release
   localparam int BitCycles   = 4 * QuarterCycles;
   localparam int ByteCycles  = 9 * BitCycles;
   localparam int StartLag    = 2;     // negedges from a START's first cycle to the monitor

   logic        CLK_400K;
   logic        RESET_N;
   wire         i2cScl;
   wire         i2cSda;
   logic [7:0]  chipId;
   logic        cameraRelease;
   logic [7:0]  idAnswer;
   logic        startSeen;
   logic        txnDone;
   logic        txnRead;
   logic [2:0]  txnLen;
   logic [31:0] txnBytes;

   logic [35:0] vectors [VectorDepth];
   logic [7:0]  answers [$];
   busWrite_t   writes [$];
   int          minIdle [$];   // idle cycles required before each write

   int          answerIdx;
   int          writeIdx;
   int          sinceReset;
   int          idleCount;
   int          cycleCount;
   int          timeoutLimit;
   logic        idMatched;
   logic        readPending;   // chipId compared at the next start
   logic        busIdle;
   logic        released;
   logic [7:0]  lastAnswer;

   pullup (i2cScl);
   pullup (i2cSda);

   tbClock i_tbClock (.CLK_400K(CLK_400K), .RESET_N(RESET_N));

   cameraConfig i_cameraConfig (
      .CLK_400K      (CLK_400K),
      .RESET_N       (RESET_N),
      .i2cScl        (i2cScl),
      .i2cSda        (i2cSda),
      .chipId        (chipId),
      .cameraRelease (cameraRelease)
   );

   sensorModel i_sensorModel (
      .CLK_400K  (CLK_400K),
      .RESET_N   (RESET_N),
      .scl       (i2cScl),
      .sda       (i2cSda),
      .idAnswer  (idAnswer),
      .startSeen (startSeen),
      .txnDone   (txnDone),
      .txnRead   (txnRead),
      .txnLen    (txnLen),
      .txnBytes  (txnBytes)
   );

   task automatic failRun(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first failure");
   endtask

   function automatic int frameCycles(input int bytes);
      return 2 * BitCycles + bytes * ByteCycles;   // start and stop take a bit slot each
   endfunction

   task automatic loadVectors();
      int pendingIdle;
      logic atEnd;
      pendingIdle = 0;
      atEnd       = 1'b0;
      for (int i = 0; i < VectorDepth; i++)
         vectors[i] = 36'(i);   // kind 0 ends the list
      $readmemh("testbench/cameraConfigVectors.txt", vectors);
      for (int i = 0; (i < VectorDepth) && !atEnd; i++) begin
         case (vectors[i][35:32])
            4'h1: answers.push_back(vectors[i][7:0]);
            4'h2: begin
               writes.push_back(busWrite_t'(vectors[i][31:0]));
               minIdle.push_back(pendingIdle);
               pendingIdle = 0;
            end
            4'h3: pendingIdle = int'(vectors[i][7:0]);
            4'h0: atEnd = 1'b1;
            default: failRun($sformatf("unknown entry kind in vector line %0d", i));
         endcase
      end
   endtask

   task automatic checkStart();
      assert (sinceReset >= SettleCycles + 1 + StartLag)
         else failRun($sformatf("bus START %0d cycles after reset, inside the settle time",
                                sinceReset - StartLag));
      assert (!released) else failRun("bus activity after cameraRelease rose");
      if (readPending) begin
         assert (chipId == lastAnswer)
            else failRun($sformatf("[ERROR] chipId: got %h expected %h", chipId, lastAnswer));
         readPending = 1'b0;
      end
      if (idMatched && busIdle && (writeIdx < writes.size())) begin
         assert (idleCount >= minIdle[writeIdx])
            else failRun($sformatf("[ERROR] idleCount before write %0d: got %h expected >= %h",
                                   writeIdx, idleCount, minIdle[writeIdx]));
      end
      busIdle = 1'b0;
   endtask

   task automatic checkTransfer();
      busIdle   = 1'b1;
      idleCount = 0;
      if (!idMatched && txnRead) begin
         assert (txnLen == 3'd2)
            else failRun($sformatf("[ERROR] txnLen: got %h expected %h", txnLen, 3'd2));
         assert (txnBytes[15:8] == (SensorAddr | 8'h01))
            else failRun($sformatf("[ERROR] i2cSda read address: got %h expected %h",
                                   txnBytes[15:8], SensorAddr | 8'h01));
         lastAnswer = answers[answerIdx];
         assert (txnBytes[7:0] == lastAnswer)
            else failRun($sformatf("[ERROR] i2cSda read byte: got %h expected %h",
                                   txnBytes[7:0], lastAnswer));
         readPending = 1'b1;
         if (lastAnswer == ChipIdExpected)
            idMatched = 1'b1;
         else
            answerIdx++;
      end else if (!idMatched) begin
         assert ((txnLen == 3'd3) && (txnBytes[23:0] == {SensorAddr, ChipIdReg}))
            else failRun($sformatf("[ERROR] txnBytes before ID match: got %h expected %h",
                                   txnBytes[23:0], {SensorAddr, ChipIdReg}));
      end else begin
         assert (!txnRead) else failRun("ID read after the chip ID had matched");
         assert (writeIdx < writes.size()) else failRun("more table writes than expected");
         assert (txnLen == 3'd4)
            else failRun($sformatf("[ERROR] txnLen: got %h expected %h", txnLen, 3'd4));
         assert (txnBytes == writes[writeIdx])
            else failRun($sformatf("[ERROR] txnBytes of write %0d: got %h expected %h",
                                   writeIdx, txnBytes, writes[writeIdx]));
         writeIdx++;
      end
   endtask

   // bus monitor on the falling edge, where model outputs are stable
   always @(negedge CLK_400K) begin
      if (!RESET_N) begin
         sinceReset  = 0;
         answerIdx   = 0;
         writeIdx    = 0;
         idleCount   = 0;
         idMatched   = 1'b0;
         readPending = 1'b0;
         busIdle     = 1'b0;
         released    = 1'b0;
         lastAnswer  = 8'h00;
         idAnswer   <= 8'h00;
      end else begin
         sinceReset++;
         if (released) begin
            assert (cameraRelease) else failRun("cameraRelease dropped after it rose");
         end
         if (cameraRelease) begin
            assert (writeIdx == writes.size())
               else failRun("cameraRelease rose before the last table write finished");
            released = 1'b1;
         end
         if (startSeen)
            checkStart();
         else if (busIdle)
            idleCount++;
         if (txnDone)
            checkTransfer();
         if (answerIdx < answers.size())
            idAnswer <= answers[answerIdx];
      end
   end

   always @(posedge CLK_400K) begin
      cycleCount++;
      if (timeoutLimit > 0) begin
         assert (cycleCount < timeoutLimit)
            else failRun($sformatf("no finished run after %0d cycles, timed out", cycleCount));
      end
   end

   initial begin
      int extra;
      logic [7:0] wrong;
      void'($urandom(46992));
      loadVectors();
      assert ((answers.size() > 0) && (writes.size() > 0))
         else failRun("vector file holds no ID answers or no writes");
      assert (answers[answers.size() - 1] == ChipIdExpected)
         else failRun("last ID answer in the vector file is not the expected chip ID");
      extra = int'($urandom_range(3, 0));
      repeat (extra) begin
         wrong = 8'($urandom_range(254, 0));
         if (wrong >= ChipIdExpected)
            wrong = wrong + 8'd1;   // skips the real id
         answers.push_front(wrong);
      end
      timeoutLimit = SettleCycles + 1 + 8;
      timeoutLimit += answers.size() * (frameCycles(3) + frameCycles(2) + 2 * GapCycles + 2);
      timeoutLimit += writes.size() * (frameCycles(4) + GapCycles + 2);
      foreach (minIdle[i])
         timeoutLimit += minIdle[i];
      timeoutLimit = 2 * timeoutLimit + TailCycles;
      wait (RESET_N);
      wait (cameraRelease);
      repeat (TailCycles) @(posedge CLK_400K);
      if (writeIdx == writes.size()) begin
         $display("TEST OK");
         $finish;
      end else begin
         failRun($sformatf("release after %0d of %0d table writes", writeIdx, writes.size()));
      end
   end

endmodule

// ==== testbench/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
   output logic CLK_400K,
   output logic RESET_N
);
   localparam int ResetCycles = 3;

   initial begin
      CLK_400K = 1'b0;
      forever #10 CLK_400K = ~CLK_400K;   // 20 ns period
   end

   initial begin
      RESET_N = 1'b0;
      repeat (ResetCycles) @(posedge CLK_400K);
      #1 RESET_N = 1'b1;   // released just after the edge
   end

endmodule
